/* Makefile */
SRCS := $(shell grep -v '^+' flist.f) src/ks_settings.svh

obj_dir/Vtb_key_switch: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_key_switch -o Vtb_key_switch

.PHONY: run clean

run: obj_dir/Vtb_key_switch
	./obj_dir/Vtb_key_switch | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* flist.f */
+incdir+src
src/ks_data_pkg.sv
src/ks_ctrl_pkg.sv
src/ks_blwe_ram.sv
src/ks_control.sv
src/ks_mult.sv
src/ks_result_format.sv
src/key_switch.sv
testbench/tb_clock_gen.sv
testbench/tb_key_switch.sv

/* src/key_switch.sv */
/*
  LWE key-switch engine top level.
  Load ciphertexts and the KSK, then send pid commands; results come back under credits.
*/
`timescale 1ns/1ns
`include "ks_settings.svh"

module key_switch
  import ks_data_pkg::*;
  import ks_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         s_rst_n,

  // Loader
  input  logic         ldb_wr_en,
  input  ks_pid_t      ldb_wr_pid,
  input  ks_coef_t     ldb_wr_data,
  input  logic         ldb_wr_last,

  // KSK write port
  input  logic         ksk_wr_en,
  input  ks_ksk_addr_t ksk_wr_addr,
  input  ks_ksk_row_t  ksk_wr_data,

  // Sequencer commands
  input  ks_pid_t      seq_cmd_pid,
  input  logic         seq_cmd_vld,
  output logic         seq_cmd_credit,

  // Results
  output logic         ks_res_vld,
  output ks_res_t      ks_res_data,
  output ks_pid_t      ks_res_pid,
  output logic         ks_res_last,
  input  logic         ks_res_credit,

  output ks_error_t    ks_error
);

  logic                   ctrl_rd_en;
  ks_ram_addr_t           ctrl_rd_addr;
  ks_coef_t               rd_data;
  logic                   ctrl_consume_en;
  ks_pid_t                ctrl_consume_pid;
  logic [`KS_SLOT_NB-1:0] slot_loaded;

  logic                   ctrl_mult_vld;
  ks_digit_t              ctrl_mult_digit;
  ks_ksk_addr_t           ctrl_mult_addr;
  logic                   ctrl_mult_last;

  ks_coef_t               ctrl_fmt_body;
  ks_pid_t                ctrl_fmt_pid;
  logic                   ctrl_fmt_body_vld;
  logic                   fmt_buf_credit;

  ks_coef_t [`KS_LWE_N:0] mult_fmt_acc;
  logic                   mult_fmt_vld;
  logic                   err_unloaded;

  // ------------------------------
  // Sticky error
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ks_error <= '0;
    end else begin
      ks_error[0] <= ks_error[0] | err_unloaded;
      ks_error[1] <= 1'b0;
    end
  end

  ks_blwe_ram u_blwe_ram (
    .clk              (clk),
    .s_rst_n          (s_rst_n),
    .ldb_wr_en        (ldb_wr_en),
    .ldb_wr_pid       (ldb_wr_pid),
    .ldb_wr_data      (ldb_wr_data),
    .ldb_wr_last      (ldb_wr_last),
    .ctrl_rd_en       (ctrl_rd_en),
    .ctrl_rd_addr     (ctrl_rd_addr),
    .ctrl_consume_en  (ctrl_consume_en),
    .ctrl_consume_pid (ctrl_consume_pid),
    .rd_data          (rd_data),
    .slot_loaded      (slot_loaded)
  );

  ks_control u_control (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .seq_cmd_pid       (seq_cmd_pid),
    .seq_cmd_vld       (seq_cmd_vld),
    .seq_cmd_credit    (seq_cmd_credit),
    .slot_loaded       (slot_loaded),
    .rd_data           (rd_data),
    .ctrl_rd_en        (ctrl_rd_en),
    .ctrl_rd_addr      (ctrl_rd_addr),
    .ctrl_consume_en   (ctrl_consume_en),
    .ctrl_consume_pid  (ctrl_consume_pid),
    .ctrl_mult_vld     (ctrl_mult_vld),
    .ctrl_mult_digit   (ctrl_mult_digit),
    .ctrl_mult_addr    (ctrl_mult_addr),
    .ctrl_mult_last    (ctrl_mult_last),
    .ctrl_fmt_body     (ctrl_fmt_body),
    .ctrl_fmt_pid      (ctrl_fmt_pid),
    .ctrl_fmt_body_vld (ctrl_fmt_body_vld),
    .fmt_buf_credit    (fmt_buf_credit),
    .err_unloaded      (err_unloaded)
  );

  ks_mult u_mult (
    .clk             (clk),
    .s_rst_n         (s_rst_n),
    .ksk_wr_en       (ksk_wr_en),
    .ksk_wr_addr     (ksk_wr_addr),
    .ksk_wr_data     (ksk_wr_data),
    .ctrl_mult_vld   (ctrl_mult_vld),
    .ctrl_mult_digit (ctrl_mult_digit),
    .ctrl_mult_addr  (ctrl_mult_addr),
    .ctrl_mult_last  (ctrl_mult_last),
    .mult_fmt_acc    (mult_fmt_acc),
    .mult_fmt_vld    (mult_fmt_vld)
  );

  ks_result_format u_result_format (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .mult_fmt_acc      (mult_fmt_acc),
    .mult_fmt_vld      (mult_fmt_vld),
    .ctrl_fmt_body     (ctrl_fmt_body),
    .ctrl_fmt_pid      (ctrl_fmt_pid),
    .ctrl_fmt_body_vld (ctrl_fmt_body_vld),
    .fmt_buf_credit    (fmt_buf_credit),
    .ks_res_vld        (ks_res_vld),
    .ks_res_data       (ks_res_data),
    .ks_res_pid        (ks_res_pid),
    .ks_res_last       (ks_res_last),
    .ks_res_credit     (ks_res_credit)
  );

endmodule

/* src/ks_blwe_ram.sv */
/*
  Coefficient RAM holding one blind-rotated LWE per slot.
  The loader writes a_0..a_7 then b; control reads with one cycle latency.
*/
`timescale 1ns/1ns
`include "ks_settings.svh"

module ks_blwe_ram
  import ks_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   s_rst_n,

  input  logic                   ldb_wr_en,
  input  ks_pid_t                ldb_wr_pid,
  input  ks_coef_t               ldb_wr_data,
  input  logic                   ldb_wr_last,

  input  logic                   ctrl_rd_en,
  input  ks_ram_addr_t           ctrl_rd_addr,
  input  logic                   ctrl_consume_en,
  input  ks_pid_t                ctrl_consume_pid,

  output ks_coef_t               rd_data,
  output logic [`KS_SLOT_NB-1:0] slot_loaded
);

  localparam int CT_WORDS = `KS_BLWE_N + 1;
  localparam int PTR_W    = $clog2(CT_WORDS);

  ks_coef_t         mem [`KS_SLOT_NB*CT_WORDS];
  logic [PTR_W-1:0] wr_ptr;
  ks_ram_addr_t     wr_addr;

  assign wr_addr = ks_ram_addr_t'(ldb_wr_pid) * ks_ram_addr_t'(CT_WORDS)
                 + ks_ram_addr_t'(wr_ptr);

  always_ff @(posedge clk) begin
    if (ldb_wr_en) begin
      mem[wr_addr] <= ldb_wr_data;
    end
    if (ctrl_rd_en) begin
      rd_data <= mem[ctrl_rd_addr];
    end
  end

  // Write pointer and loaded flags
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr      <= '0;
      slot_loaded <= '0;
    end else begin
      if (ldb_wr_en) begin
        wr_ptr <= ldb_wr_last ? '0 : wr_ptr + PTR_W'(1);
      end
      if (ctrl_consume_en) begin
        slot_loaded[ctrl_consume_pid] <= 1'b0;
      end
      if (ldb_wr_en && ldb_wr_last) begin
        slot_loaded[ldb_wr_pid] <= 1'b1;
      end
    end
  end

  // Loader must wait until control has consumed the slot
  a_no_overwrite : assert property (@(posedge clk) disable iff (!s_rst_n)
    ldb_wr_en |-> !slot_loaded[ldb_wr_pid]);

endmodule

/* src/ks_control.sv */
/*
  Command queue and sequencing of one key switch per pid command.
  Reads the slot, rounds each mask coefficient to 8 bits and issues two digits each.
*/
`timescale 1ns/1ns
`include "ks_settings.svh"

module ks_control
  import ks_data_pkg::*;
  import ks_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   s_rst_n,

  input  ks_pid_t                seq_cmd_pid,
  input  logic                   seq_cmd_vld,
  output logic                   seq_cmd_credit,

  input  logic [`KS_SLOT_NB-1:0] slot_loaded,
  input  ks_coef_t               rd_data,
  output logic                   ctrl_rd_en,
  output ks_ram_addr_t           ctrl_rd_addr,
  output logic                   ctrl_consume_en,
  output ks_pid_t                ctrl_consume_pid,

  output logic                   ctrl_mult_vld,
  output ks_digit_t              ctrl_mult_digit,
  output ks_ksk_addr_t           ctrl_mult_addr,
  output logic                   ctrl_mult_last,

  output ks_coef_t               ctrl_fmt_body,
  output ks_pid_t                ctrl_fmt_pid,
  output logic                   ctrl_fmt_body_vld,
  input  logic                   fmt_buf_credit,

  output logic                   err_unloaded
);

  localparam int Q_PTR_W  = $clog2(`KS_CMD_DEPTH);
  localparam int Q_CNT_W  = $clog2(`KS_CMD_DEPTH + 1);
  localparam int BUF_CR_W = $clog2(`KS_FMT_BUF_NB + 1);
  localparam int RD_IDX_W = $clog2(`KS_BLWE_N + 1);
  localparam int RND_W    = `KS_BASE_LOG * `KS_LEVEL;
  localparam ks_coef_t     RND_HALF   = ks_coef_t'(1 << (`KS_MOD_W - RND_W - 1));
  localparam ks_ksk_addr_t LAST_DIGIT = ks_ksk_addr_t'(`KS_BLWE_N * `KS_LEVEL - 1);

  ks_pid_t             cmd_q [`KS_CMD_DEPTH];
  logic [Q_PTR_W-1:0]  q_wp;
  logic [Q_PTR_W-1:0]  q_rp;
  logic [Q_CNT_W-1:0]  q_cnt;
  logic                q_pop;

  ks_ctrl_state_t      state;
  ks_ctrl_state_t      state_n;
  ks_pid_t             cur_pid;
  ks_ksk_addr_t        dig_cnt;
  logic [BUF_CR_W-1:0] buf_credits;
  logic                cmd_ok;
  logic [RD_IDX_W-1:0] rd_idx;
  ks_coef_t            round_sum;
  logic [RND_W-1:0]    rounded;

  assign q_pop        = (state == CTRL_IDLE) && (q_cnt != '0) && (buf_credits != '0);
  assign cmd_ok       = (state == CTRL_CHECK) && slot_loaded[cur_pid];
  assign err_unloaded = (state == CTRL_CHECK) && !slot_loaded[cur_pid];

  always_comb begin
    state_n = state;
    case (state)
      CTRL_IDLE:   if (q_pop) state_n = CTRL_CHECK;
      CTRL_CHECK:  state_n = cmd_ok ? CTRL_DIGITS : CTRL_IDLE;
      CTRL_DIGITS: if (dig_cnt == LAST_DIGIT) state_n = CTRL_BODY;
      default:     state_n = CTRL_IDLE;
    endcase
  end

  // ------------------------------
  // Slot reads
  // ------------------------------
  // Next coefficient is fetched on the low digit, the body after the last one
  assign ctrl_rd_en   = cmd_ok || ((state == CTRL_DIGITS) && dig_cnt[0]);
  assign rd_idx       = cmd_ok ? '0 : RD_IDX_W'(dig_cnt >> 1) + RD_IDX_W'(1);
  assign ctrl_rd_addr = ks_ram_addr_t'(cur_pid) * ks_ram_addr_t'(`KS_BLWE_N + 1)
                      + ks_ram_addr_t'(rd_idx);

  assign ctrl_consume_en  = (state == CTRL_BODY);
  assign ctrl_consume_pid = cur_pid;

  // Round to nearest on the top 8 bits
  assign round_sum = rd_data + RND_HALF;
  assign rounded   = round_sum[`KS_MOD_W-1 -: RND_W];

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state             <= CTRL_IDLE;
      q_wp              <= '0;
      q_rp              <= '0;
      q_cnt             <= '0;
      buf_credits       <= BUF_CR_W'(`KS_FMT_BUF_NB);
      dig_cnt           <= '0;
      seq_cmd_credit    <= 1'b0;
      ctrl_mult_vld     <= 1'b0;
      ctrl_fmt_body_vld <= 1'b0;
    end else begin
      state             <= state_n;
      seq_cmd_credit    <= q_pop;
      ctrl_mult_vld     <= (state == CTRL_DIGITS);
      ctrl_fmt_body_vld <= (state == CTRL_BODY);
      if (seq_cmd_vld) q_wp <= q_wp + Q_PTR_W'(1);
      if (q_pop) q_rp <= q_rp + Q_PTR_W'(1);
      q_cnt       <= q_cnt + Q_CNT_W'(seq_cmd_vld) - Q_CNT_W'(q_pop);
      // A dropped command never takes a buffer
      buf_credits <= buf_credits + BUF_CR_W'(fmt_buf_credit) - BUF_CR_W'(cmd_ok);
      if (cmd_ok) begin
        dig_cnt <= '0;
      end else if (state == CTRL_DIGITS) begin
        dig_cnt <= dig_cnt + ks_ksk_addr_t'(1);
      end
    end
  end

  // Queue storage and digit stream
  always_ff @(posedge clk) begin
    if (seq_cmd_vld) cmd_q[q_wp] <= seq_cmd_pid;
    if (q_pop) cur_pid <= cmd_q[q_rp];
    // High digit first
    ctrl_mult_digit <= dig_cnt[0] ? rounded[`KS_BASE_LOG-1:0]
                                  : rounded[RND_W-1 -: `KS_BASE_LOG];
    ctrl_mult_addr  <= dig_cnt;
    ctrl_mult_last  <= (dig_cnt == LAST_DIGIT);
    ctrl_fmt_body   <= rd_data;
    ctrl_fmt_pid    <= cur_pid;
  end

  // Sequencer only sends while holding a credit
  a_cmd_q_no_ovf : assert property (@(posedge clk) disable iff (!s_rst_n)
    seq_cmd_vld |-> (q_cnt < Q_CNT_W'(`KS_CMD_DEPTH)));

endmodule

/* src/ks_ctrl_pkg.sv */
/*
  Control types of the key-switch engine.
  Import with ks_ctrl_pkg::* where the FSM or the error vector is needed.
*/
package ks_ctrl_pkg;

  // ------------------------------
  // Command FSM
  // ------------------------------
  typedef enum logic [1:0] {
    CTRL_IDLE   = 2'd0,
    CTRL_CHECK  = 2'd1,
    CTRL_DIGITS = 2'd2,
    CTRL_BODY   = 2'd3
  } ks_ctrl_state_t;

  // ------------------------------
  // Error vector
  // ------------------------------
  // Bit 0 is a command on an unloaded slot, bit 1 reserved
  typedef logic [1:0] ks_error_t;

endpackage

/* src/ks_data_pkg.sv */
/*
  Data vectors carried between the key-switch blocks.
  Import with ks_data_pkg::* in the module header.
*/
`include "ks_settings.svh"

package ks_data_pkg;

  // One coefficient mod 2^16, also one accumulator lane
  typedef logic [`KS_MOD_W-1:0] ks_coef_t;

  typedef logic [`KS_BASE_LOG-1:0] ks_digit_t;

  // Mod-switched output word
  typedef logic [`KS_MS_W-1:0] ks_res_t;

  typedef logic [$clog2(`KS_SLOT_NB)-1:0] ks_pid_t;

  // Four mask lanes then the body lane in the top 16 bits
  typedef logic [(`KS_LWE_N+1)*`KS_MOD_W-1:0] ks_ksk_row_t;

  // Row index is coefficient * KS_LEVEL + level
  typedef logic [$clog2(`KS_BLWE_N*`KS_LEVEL)-1:0] ks_ksk_addr_t;

  // Flat coefficient RAM address, slot * 9 + word
  typedef logic [$clog2(`KS_SLOT_NB*(`KS_BLWE_N+1))-1:0] ks_ram_addr_t;

endpackage

/* src/ks_mult.sv */
/*
  KSK storage and five-lane multiply-accumulate.
  Stage 1 reads the KSK row, stage 2 accumulates digit * lane mod 2^16.
*/
`timescale 1ns/1ns
`include "ks_settings.svh"

module ks_mult
  import ks_data_pkg::*;
(
  input  logic                          clk,
  input  logic                          s_rst_n,

  input  logic                          ksk_wr_en,
  input  ks_ksk_addr_t                  ksk_wr_addr,
  input  ks_ksk_row_t                   ksk_wr_data,

  input  logic                          ctrl_mult_vld,
  input  ks_digit_t                     ctrl_mult_digit,
  input  ks_ksk_addr_t                  ctrl_mult_addr,
  input  logic                          ctrl_mult_last,

  output ks_coef_t [`KS_LWE_N:0]        mult_fmt_acc,
  output logic                          mult_fmt_vld
);

  localparam int LANES    = `KS_LWE_N + 1;
  localparam int KSK_ROWS = `KS_BLWE_N * `KS_LEVEL;

  ks_ksk_row_t           ksk_mem [KSK_ROWS];

  logic                  s1_vld;
  logic                  s1_last;
  ks_digit_t             s1_digit;
  ks_ksk_row_t           s1_row;

  ks_coef_t [LANES-1:0]  acc;
  ks_coef_t [LANES-1:0]  acc_sum;

  always_ff @(posedge clk) begin
    if (ksk_wr_en) begin
      ksk_mem[ksk_wr_addr] <= ksk_wr_data;
    end
  end

  // ------------------------------
  // Stage 1: KSK row read
  // ------------------------------
  always_ff @(posedge clk) begin
    s1_digit <= ctrl_mult_digit;
    s1_last  <= ctrl_mult_last;
    s1_row   <= ksk_mem[ctrl_mult_addr];
  end

  // ------------------------------
  // Stage 2: accumulate
  // ------------------------------
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      acc_sum[l] = acc[l] + s1_row[l*`KS_MOD_W +: `KS_MOD_W] * ks_coef_t'(s1_digit);
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_vld       <= 1'b0;
      acc          <= '0;
      mult_fmt_vld <= 1'b0;
    end else begin
      s1_vld       <= ctrl_mult_vld;
      mult_fmt_vld <= s1_vld && s1_last;
      // Next ciphertext starts from zero
      if (s1_vld) begin
        acc <= s1_last ? '0 : acc_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld && s1_last) begin
      mult_fmt_acc <= acc_sum;
    end
  end

endmodule

/* src/ks_result_format.sv */
/*
  Result buffer, output forming and serialization.
  Words go out as a'_0..a'_3 then b', each mod-switched to 10 bits, under credits.
*/
`timescale 1ns/1ns
`include "ks_settings.svh"

module ks_result_format
  import ks_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   s_rst_n,

  input  ks_coef_t [`KS_LWE_N:0] mult_fmt_acc,
  input  logic                   mult_fmt_vld,
  input  ks_coef_t               ctrl_fmt_body,
  input  ks_pid_t                ctrl_fmt_pid,
  input  logic                   ctrl_fmt_body_vld,
  output logic                   fmt_buf_credit,

  output logic                   ks_res_vld,
  output ks_res_t                ks_res_data,
  output ks_pid_t                ks_res_pid,
  output logic                   ks_res_last,
  input  logic                   ks_res_credit
);

  localparam int LANES  = `KS_LWE_N + 1;
  localparam int BUF_NB = `KS_FMT_BUF_NB;
  localparam int BUF_W  = $clog2(BUF_NB);
  localparam int WORD_W = $clog2(LANES);
  localparam int CR_W   = $clog2(`KS_RES_CREDITS + 1);
  localparam ks_coef_t MS_HALF = ks_coef_t'(1 << (`KS_MOD_W - `KS_MS_W - 1));

  ks_coef_t [LANES-1:0] buf_acc [BUF_NB];
  ks_coef_t             buf_body [BUF_NB];
  ks_pid_t              buf_pid [BUF_NB];
  logic [BUF_NB-1:0]    body_ok;
  logic [BUF_NB-1:0]    acc_ok;
  logic [BUF_W-1:0]     body_wp;
  logic [BUF_W-1:0]     acc_wp;
  logic [BUF_W-1:0]     rd_ptr;

  logic [WORD_W-1:0]    word_idx;
  logic [CR_W-1:0]      cr_cnt;
  logic                 fire;
  logic                 last_word;
  ks_coef_t             word;
  ks_coef_t             ms_sum;

  assign fire      = body_ok[rd_ptr] && acc_ok[rd_ptr] && (cr_cnt != '0);
  assign last_word = (word_idx == WORD_W'(LANES - 1));

  // a'_j = -acc_j, b' = b - acc_body, then add half and keep the top bits
  always_comb begin
    if (last_word) begin
      word = buf_body[rd_ptr] - buf_acc[rd_ptr][word_idx];
    end else begin
      word = ks_coef_t'(0) - buf_acc[rd_ptr][word_idx];
    end
    ms_sum = word + MS_HALF;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      body_ok        <= '0;
      acc_ok         <= '0;
      body_wp        <= '0;
      acc_wp         <= '0;
      rd_ptr         <= '0;
      word_idx       <= '0;
      cr_cnt         <= CR_W'(`KS_RES_CREDITS);
      ks_res_vld     <= 1'b0;
      fmt_buf_credit <= 1'b0;
    end else begin
      ks_res_vld     <= fire;
      fmt_buf_credit <= fire && last_word;
      cr_cnt         <= cr_cnt + CR_W'(ks_res_credit) - CR_W'(fire);
      if (fire) begin
        if (last_word) begin
          word_idx        <= '0;
          body_ok[rd_ptr] <= 1'b0;
          acc_ok[rd_ptr]  <= 1'b0;
          rd_ptr          <= rd_ptr + BUF_W'(1);
        end else begin
          word_idx <= word_idx + WORD_W'(1);
        end
      end
      if (ctrl_fmt_body_vld) begin
        body_ok[body_wp] <= 1'b1;
        body_wp          <= body_wp + BUF_W'(1);
      end
      if (mult_fmt_vld) begin
        acc_ok[acc_wp] <= 1'b1;
        acc_wp         <= acc_wp + BUF_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_fmt_body_vld) begin
      buf_body[body_wp] <= ctrl_fmt_body;
      buf_pid[body_wp]  <= ctrl_fmt_pid;
    end
    if (mult_fmt_vld) begin
      buf_acc[acc_wp] <= mult_fmt_acc;
    end
    ks_res_data <= ms_sum[`KS_MOD_W-1 -: `KS_MS_W];
    ks_res_pid  <= buf_pid[rd_ptr];
    ks_res_last <= last_word;
  end

  // Consumer never returns more than it was given
  a_cr_max : assert property (@(posedge clk) disable iff (!s_rst_n)
    cr_cnt <= CR_W'(`KS_RES_CREDITS));

endmodule

/* src/ks_settings.svh */
/*
  Widths and counts of the key-switch engine.
  Included by the packages and by every module that sizes a port or array.
*/
`ifndef KS_SETTINGS_SVH
`define KS_SETTINGS_SVH

// Ciphertext shape
`define KS_BLWE_N       8
`define KS_LWE_N        4
`define KS_MOD_W        16

// Decomposition
`define KS_BASE_LOG     4
`define KS_LEVEL        2

// Mod switch to 2N, N = 512
`define KS_MS_W         10

// Slots, queues and credits
`define KS_SLOT_NB      4
`define KS_CMD_DEPTH    2
`define KS_RES_CREDITS  4
`define KS_FMT_BUF_NB   2

`endif

/* testbench/tb_clock_gen.sv */
/*
  Clock and reset source for the key-switch testbench.
  8 ns clock, synchronous reset held low for 5 cycles.
*/
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic s_rst_n
);

  initial begin
    clk     = 1'b0;
    s_rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 s_rst_n = 1'b1;
  end

  always #4 clk = ~clk;

endmodule

/* testbench/tb_key_switch.sv */
/*
  Testbench of the key-switch engine.
  Drives loads, KSK writes and commands; assertions compare each output word
  with a reference model queued in command order.
*/
`timescale 1ns/1ns
`include "ks_settings.svh"

module tb_key_switch
  import ks_data_pkg::*;
  import ks_ctrl_pkg::*;
;

  localparam int N_CMDS   = 10;
  localparam int WATCH_NS = 20000 + 200 * N_CMDS * 8;

  logic clk, s_rst_n;
  logic ldb_wr_en, ldb_wr_last, ksk_wr_en, seq_cmd_vld, seq_cmd_credit;
  logic ks_res_vld, ks_res_last, ks_res_credit;
  ks_pid_t ldb_wr_pid, seq_cmd_pid, ks_res_pid;
  ks_coef_t ldb_wr_data;
  ks_ksk_addr_t ksk_wr_addr;
  ks_ksk_row_t ksk_wr_data;
  ks_res_t ks_res_data;
  ks_error_t ks_error;

  integer seed = 49437;
  int err_cnt, rd_idx, wr_idx, out_cnt, granted, cmd_credits, pend, release_req;
  logic auto_credit;
  ks_res_t exp_data [64];
  ks_pid_t exp_pid [64];
  logic exp_last [64];
  ks_coef_t ksk_lane [16][5];
  ks_coef_t slot_ct [4][9];

  tb_clock_gen u_clk (.clk(clk), .s_rst_n(s_rst_n));

  key_switch u_dut (.*);

  // ------------------------------
  // Checking
  // ------------------------------
  a_word : assert property (@(posedge clk) disable iff (!s_rst_n)
    ks_res_vld |-> (rd_idx < wr_idx && ks_res_data == exp_data[rd_idx]
                    && ks_res_pid == exp_pid[rd_idx] && ks_res_last == exp_last[rd_idx]))
    else begin
      err_cnt++;
      $display("MISMATCH at %0t: word %0d got %h pid %0d last %b", $time, rd_idx,
               ks_res_data, ks_res_pid, ks_res_last);
    end

  a_credit : assert property (@(posedge clk) disable iff (!s_rst_n)
    ks_res_vld |-> (out_cnt < granted))
    else begin
      err_cnt++;
      $display("Word %0d sent at %0t without a consumer credit", out_cnt, $time);
    end

  always @(posedge clk) begin
    if (ks_res_vld) begin
      rd_idx  <= rd_idx + 1;
      out_cnt <= out_cnt + 1;
    end
    if (ks_res_credit) granted <= granted + 1;
    if (seq_cmd_credit) cmd_credits++;
  end

  // Consumer credit return
  always @(posedge clk) begin
    #1;
    if (auto_credit && ks_res_vld) pend++;
    pend += release_req;
    release_req = 0;
    ks_res_credit = (pend > 0);
    if (pend > 0) pend--;
  end

  initial begin
    #(WATCH_NS);
    $display("Timeout: run did not finish within %0d ns", WATCH_NS);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic write_ksk(input bit zero);
    for (int r = 0; r < 16; r++) begin
      ksk_wr_en   = 1'b1;
      ksk_wr_addr = ks_ksk_addr_t'(r);
      for (int l = 0; l < 5; l++) begin
        ksk_lane[r][l] = zero ? '0 : ks_coef_t'($random(seed));
        ksk_wr_data[l*16 +: 16] = ksk_lane[r][l];
      end
      tick();
    end
    ksk_wr_en = 1'b0;
  endtask

  task automatic load_ct(input int pid);
    for (int w = 0; w < 9; w++) begin
      slot_ct[pid][w] = ks_coef_t'($random(seed));
      ldb_wr_en   = 1'b1;
      ldb_wr_pid  = ks_pid_t'(pid);
      ldb_wr_data = slot_ct[pid][w];
      ldb_wr_last = (w == 8);
      tick();
    end
    ldb_wr_en   = 1'b0;
    ldb_wr_last = 1'b0;
  endtask

  // Reference key switch of one slot, queued as five expected words
  task automatic push_expected(input int pid);
    logic [15:0] acc [5];
    logic [15:0] r, w;
    for (int l = 0; l < 5; l++) acc[l] = '0;
    for (int i = 0; i < 8; i++) begin
      r = (slot_ct[pid][i] + 16'd128) >> 8;
      for (int l = 0; l < 5; l++) begin
        acc[l] = acc[l] + ksk_lane[2*i][l] * {12'd0, r[7:4]}
                        + ksk_lane[2*i+1][l] * {12'd0, r[3:0]};
      end
    end
    for (int j = 0; j < 5; j++) begin
      w = (j == 4) ? slot_ct[pid][8] - acc[4] : 16'd0 - acc[j];
      w = w + 16'd32;
      exp_data[wr_idx] = w[15:6];
      exp_pid[wr_idx]  = ks_pid_t'(pid);
      exp_last[wr_idx] = (j == 4);
      wr_idx++;
    end
  endtask

  task automatic send_cmd(input int pid, input bit loaded);
    while (cmd_credits == 0) tick();
    if (loaded) push_expected(pid);
    cmd_credits--;
    seq_cmd_vld = 1'b1;
    seq_cmd_pid = ks_pid_t'(pid);
    tick();
    seq_cmd_vld = 1'b0;
  endtask

  task automatic drain();
    while (rd_idx != wr_idx) tick();
    repeat (4) tick();
  endtask

  task automatic report(input string name, input int err_before);
    $display("%s: %s", name, (err_cnt == err_before) ? "ok" : "failed");
  endtask

  initial begin
    int e0, prev;
    {ldb_wr_en, ldb_wr_last, ksk_wr_en, seq_cmd_vld, ks_res_credit} = '0;
    {ldb_wr_pid, seq_cmd_pid, ldb_wr_data, ksk_wr_addr, ksk_wr_data} = '0;
    {err_cnt, rd_idx, wr_idx, out_cnt, pend, release_req} = '0;
    granted     = `KS_RES_CREDITS;
    cmd_credits = `KS_CMD_DEPTH;
    auto_credit = 1'b1;
    wait (s_rst_n);
    tick();

    e0 = err_cnt;
    assert (!ks_res_vld && !seq_cmd_credit && ks_error == '0)
      else begin
        err_cnt++;
        $display("Outputs not idle after reset");
      end
    report("reset state", e0);

    e0 = err_cnt;
    write_ksk(1'b1);
    load_ct(1);
    send_cmd(1, 1'b1);
    drain();
    report("zero KSK", e0);

    // Six ciphertexts, two batches so no slot is reloaded early
    e0 = err_cnt;
    write_ksk(1'b0);
    for (int b = 0; b < 2; b++) begin
      for (int p = 0; p < (b == 0 ? 4 : 2); p++) load_ct(p);
      for (int p = 0; p < (b == 0 ? 4 : 2); p++) send_cmd(p, 1'b1);
      drain();
    end
    report("random KSK", e0);

    e0 = err_cnt;
    auto_credit = 1'b0;
    prev = out_cnt;
    load_ct(0);
    load_ct(2);
    send_cmd(0, 1'b1);
    send_cmd(2, 1'b1);
    while (out_cnt < prev + `KS_RES_CREDITS) tick();
    repeat (60) tick();
    assert (out_cnt == prev + `KS_RES_CREDITS)
      else begin
        err_cnt++;
        $display("More words came out than credits granted");
      end
    auto_credit = 1'b1;
    release_req = `KS_RES_CREDITS;
    drain();
    report("back-pressure", e0);

    e0 = err_cnt;
    prev = out_cnt;
    assert (ks_error == '0)
      else begin
        err_cnt++;
        $display("Error flag already set before the unloaded command");
      end
    send_cmd(3, 1'b0);
    while (cmd_credits != `KS_CMD_DEPTH) tick();
    repeat (20) tick();
    assert (ks_error == 2'b01 && out_cnt == prev)
      else begin
        err_cnt++;
        $display("Unloaded pid did not raise the error or produced words");
      end
    report("unloaded pid", e0);

    $display("Words checked: %0d, errors: %0d", out_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
